// File: all.f
source/line_table_pkg.sv
source/code_buffer.sv
source/opcode_parser.sv
source/line_machine.sv
source/register_bank.sv
source/line_table_accel.sv
tests/line_table_asserts.sv
tests/line_table_tb.sv

// File: run.sh
#!/usr/bin/env bash
# Builds the line-table testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1

verilator --binary --assert -j 0 --top-module line_table_tb -f all.f -o line_table_sim \
    > build.log 2>&1 \
    || { cat build.log; echo "build failed"; exit 1; }

./obj_dir/line_table_sim > sim.log 2>&1 ; cat sim.log

grep -qx '>>> PASS' sim.log && echo "result: simulation passed" \
    || { echo "result: simulation failed"; exit 1; }

// File: tests/line_table_tb.sv
// Testbench for the DWARF line-table accelerator
// Random program generator with a fixed seed and a byte-level model of the abstract machine
// Register checks at every row interrupt, partial reads and a watchdog

module line_table_tb;
    import line_table_pkg::*;

    typedef struct packed {
        logic [31:0] address;
        logic [31:0] file;
        logic [31:0] line_col_flags;
    } row_t;

    logic        clk = 1'b0;
    logic        reset_this_cycle;
    bus_req_t    bus;
    logic [31:0] read_data;
    logic        user_interrupt;

    integer      seed = 32'h5168_1ac9;
    logic [7:0]  prog[$];
    row_t        rows[$];
    logic        header_bit = 1'b0;
    int          budget = 1000;
    int          cycles = 0;
    int          row_count = 0;

    // Model of the abstract machine
    logic [27:0] m_address;
    logic [15:0] m_file;
    logic [15:0] m_line;
    logic [9:0]  m_column;
    logic        m_is_stmt;
    logic        m_basic_block;
    logic        m_prologue_end;
    logic        m_epilogue_begin;

    line_table_accel i_line_table_accel (
        .clk              (clk),
        .reset_this_cycle (reset_this_cycle),
        .bus              (bus),
        .read_data        (read_data),
        .user_interrupt   (user_interrupt)
    );

    always #2 clk = ~clk;

    task automatic stop_run(string why);
        $display("%s", why);
        $display(">>> FAIL");
        $fatal(1, "simulation stopped at the first failure");
    endtask

    // Every chunk written adds 20 cycles to the budget
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles > budget) begin
            stop_run($sformatf("watchdog expired after %0d cycles, the DUT stopped responding",
                               cycles));
        end
    end

    function automatic logic [31:0] random_word();
        return $random(seed);
    endfunction

    function automatic logic is_kept_opcode(logic [7:0] b);
        return b inside {[8'd1:8'd7], [8'd9:8'd11]};
    endfunction

    function automatic row_t model_row();
        row_t r;
        r.address        = {4'h0, m_address};
        r.file           = {16'h0, m_file};
        r.line_col_flags = {2'b00, m_epilogue_begin, m_prologue_end, m_basic_block,
                            m_is_stmt, m_column, m_line};
        return r;
    endfunction

    task automatic reset_model(logic is_stmt);
        m_address        = 28'h0;
        m_file           = 16'h1;
        m_line           = 16'h1;
        m_column         = 10'h0;
        m_is_stmt        = is_stmt;
        m_basic_block    = 1'b0;
        m_prologue_end   = 1'b0;
        m_epilogue_begin = 1'b0;
    endtask

    task automatic compare_value(string name, logic [31:0] expected, logic [31:0] actual);
        if (actual !== expected) begin
            stop_run($sformatf("error %s: expected %h, actual %h", name, expected, actual));
        end
    endtask

    task automatic drive_bus(reg_addr_e a, logic [31:0] d, rw_size_e ws, rw_size_e rs);
        bus.address    = a;
        bus.data       = d;
        bus.write_size = ws;
        bus.read_size  = rs;
    endtask

    task automatic write_reg(reg_addr_e a, logic [31:0] d, rw_size_e ws);
        @(negedge clk);
        drive_bus(a, d, ws, RW_NONE);
    endtask

    // Reads are combinational, so the value is taken a moment after the bus settles
    task automatic check_read(reg_addr_e a, rw_size_e rs, logic [31:0] expected, string name);
        @(negedge clk);
        drive_bus(a, 32'h0, RW_NONE, rs);
        #1;
        compare_value(name, expected, read_data);
    endtask

    task automatic check_registers(string tag, row_t exp, logic [31:0] status);
        check_read(AM_ADDRESS, RW_32, exp.address, {tag, " address"});
        check_read(AM_FILE, RW_32, exp.file, {tag, " file"});
        check_read(AM_LINE_COL_FLAGS, RW_32, exp.line_col_flags, {tag, " line/column/flags"});
        check_read(STATUS, RW_32, status, {tag, " status"});
        compare_value({tag, " interrupt"}, status, {31'h0, user_interrupt});
        check_read(PROGRAM_HEADER, RW_32, {31'h0, header_bit}, {tag, " header"});
        check_read(AM_LINE_COL_FLAGS, RW_8, exp.line_col_flags & 32'hff, {tag, " 8-bit read"});
        check_read(AM_LINE_COL_FLAGS, RW_16, exp.line_col_flags & 32'hffff,
                   {tag, " 16-bit read"});
        check_read(AM_ADDRESS, RW_8, exp.address & 32'hff, {tag, " 8-bit address"});
    endtask

    // Opcode 0 in the table stands for a random byte outside the kept opcodes
    task automatic build_program(int n_instr);
        logic [7:0]  kinds[11] = '{8'h01, 8'h02, 8'h03, 8'h04, 8'h05, 8'h06,
                                   8'h07, 8'h09, 8'h0a, 8'h0b, 8'h00};
        logic [31:0] r;
        logic [7:0]  op;
        int          len;
        int          k;
        int          j;
        prog.delete();
        for (k = 0; k < n_instr; k++) begin
            r  = random_word();
            op = kinds[int'(r[7:0]) % 11];
            if (op == 8'h00) begin
                do begin
                    r = random_word();
                end while (is_kept_opcode(r[7:0]));
                prog.push_back(r[7:0]);
            end else begin
                prog.push_back(op);
                if (op inside {[8'h02:8'h05]}) begin
                    // Up to 6 LEB bytes, so some run past the 28-bit operand
                    len = 1 + int'(r[10:8]) % 6;
                    for (j = 0; j < len; j++) begin
                        r = random_word();
                        prog.push_back({j != len - 1, r[6:0]});
                    end
                end else if (op == 8'h09) begin
                    r = random_word();
                    prog.push_back(r[7:0]);
                    prog.push_back(r[15:8]);
                end
            end
        end
    endtask

    // Walks the byte stream and queues the row expected at each copy
    task automatic run_model();
        int          i;
        int          n;
        logic [7:0]  op;
        logic [7:0]  b;
        logic [27:0] val;
        rows.delete();
        i = 0;
        while (i < prog.size()) begin
            op = prog[i];
            i++;
            case (op)
                8'h01: begin
                    rows.push_back(model_row());
                    m_basic_block    = 1'b0;
                    m_prologue_end   = 1'b0;
                    m_epilogue_begin = 1'b0;
                end
                8'h02, 8'h03, 8'h04, 8'h05: begin
                    val = 28'h0;
                    n   = 0;
                    do begin
                        b = prog[i];
                        i++;
                        if (n < 4) begin
                            val = val | (28'(b[6:0]) << (7 * n));
                        end
                        n++;
                    end while (b[7]);
                    // Four bytes already fill all 28 bits
                    if (op == 8'h03 && n < 4 && b[6]) begin
                        val = val | (28'hfff_ffff << (7 * n));
                    end
                    case (op)
                        8'h02:   m_address = (m_address + val) & 28'hfff_fffe;
                        8'h03:   m_line = m_line + val[15:0];
                        8'h04:   m_file = val[15:0];
                        default: m_column = val[9:0];
                    endcase
                end
                8'h06: m_is_stmt = !m_is_stmt;
                8'h07: m_basic_block = 1'b1;
                8'h09: begin
                    m_address = (m_address + {12'h0, prog[i + 1], prog[i]}) & 28'hfff_fffe;
                    i += 2;
                end
                8'h0a: m_prologue_end = 1'b1;
                8'h0b: m_epilogue_begin = 1'b1;
                default: begin
                end
            endcase
        end
    endtask

    task automatic service_row();
        row_t  exp;
        string tag;
        if (rows.size() == 0) begin
            stop_run("the DUT raised an interrupt but the program has no copy left");
        end
        exp = rows.pop_front();
        row_count++;
        tag = $sformatf("row %0d", row_count);
        check_registers(tag, exp, 32'h1);
        write_reg(STATUS, random_word(), RW_32);
        // First cycle after the release, before the next byte takes effect
        check_read(AM_LINE_COL_FLAGS, RW_32, exp.line_col_flags & ~32'h3800_0000,
                   {tag, " flags after release"});
        compare_value({tag, " interrupt after release"}, 32'h0, {31'h0, user_interrupt});
    endtask

    task automatic idle_after_write();
        int idle;
        idle = 0;
        while (idle < 8) begin
            @(negedge clk);
            drive_bus(PROGRAM_HEADER, 32'h0, RW_NONE, RW_NONE);
            if (user_interrupt) begin
                service_row();
                idle = 0;
            end else begin
                idle++;
            end
        end
    endtask

    task automatic send_program();
        int          pos;
        int          size;
        int          j;
        logic [31:0] r;
        logic [31:0] data;
        rw_size_e    ws;
        pos = 0;
        while (pos < prog.size()) begin
            r    = random_word();
            size = r[1:0] == 2'd0 ? 1 : (r[1:0] == 2'd1 ? 2 : 4);
            if (size > prog.size() - pos) begin
                size = prog.size() - pos >= 2 ? 2 : 1;
            end
            // Lanes above the chunk keep random data that the buffer has to ignore
            data = random_word();
            for (j = 0; j < size; j++) begin
                data[8 * j +: 8] = prog[pos + j];
            end
            ws = size == 1 ? RW_8 : (size == 2 ? RW_16 : RW_32);
            pos += size;
            budget += 20;
            write_reg(PROGRAM_CODE, data, ws);
            idle_after_write();
        end
    endtask

    task automatic run_pass(int pass, int n_instr);
        logic [31:0] hdr;
        row_t        start;
        hdr        = random_word();
        header_bit = hdr[0];
        build_program(n_instr);
        reset_model(header_bit);
        start = model_row();
        run_model();
        write_reg(PROGRAM_HEADER, hdr, RW_32);
        check_registers($sformatf("pass %0d header", pass), start, 32'h0);
        send_program();
        if (rows.size() != 0) begin
            stop_run($sformatf("pass %0d ended with %0d copy rows that never raised an interrupt",
                               pass, rows.size()));
        end
        check_registers($sformatf("pass %0d end", pass), model_row(), 32'h0);
    endtask

    initial begin
        reset_this_cycle = 1'b1;
        drive_bus(PROGRAM_HEADER, 32'h0, RW_NONE, RW_NONE);
        repeat (4) @(negedge clk);
        reset_this_cycle = 1'b0;
        reset_model(1'b0);
        check_registers("after reset", model_row(), 32'h0);
        for (int p = 0; p < 3; p++) begin
            run_pass(p, 150);
        end
        if (i_line_table_accel.i_asserts.failures != 0) begin
            stop_run("the bound interrupt assertions reported failures");
        end else begin
            $display(">>> PASS");
            $finish;
        end
    end

endmodule

// File: tests/line_table_asserts.sv
// Concurrent assertions on the row interrupt of the accelerator
// Bound into the top level, with a failure count the testbench reads at the end

module line_table_asserts (
    input logic                     clk,
    input logic                     reset_this_cycle,
    input logic                     status_write,
    input line_table_pkg::bus_req_t bus,
    input logic [31:0]              read_data,
    input logic                     user_interrupt
);
    import line_table_pkg::*;

    int failures = 0;

    // STATUS bit 0 as the host reads it tracks the interrupt line
    irq_matches_status: assert property (
        @(posedge clk) disable iff (reset_this_cycle)
        (bus.address == STATUS && bus.read_size != RW_NONE)
            |-> read_data[0] == user_interrupt
    ) else begin
        failures++;
        $error("user_interrupt differs from STATUS bit 0");
    end

    // The host release always drops the interrupt for at least one cycle
    irq_low_after_release: assert property (
        @(posedge clk) status_write |=> !user_interrupt
    ) else begin
        failures++;
        $error("user_interrupt still high in the cycle after a STATUS write");
    end

    irq_low_after_reset: assert property (
        @(posedge clk) reset_this_cycle |=> !user_interrupt
    ) else begin
        failures++;
        $error("user_interrupt high in the cycle after reset");
    end

endmodule

bind line_table_accel line_table_asserts i_asserts (
    .clk              (clk),
    .reset_this_cycle (reset_this_cycle),
    .status_write     (status_write),
    .bus              (bus),
    .read_data        (read_data),
    .user_interrupt   (user_interrupt)
);

// File: source/line_table_accel.sv
// Top level of the DWARF line-table accelerator
// Connects the code buffer, opcode parser, abstract machine and register bank

module line_table_accel (
    input  logic                     clk,
    input  logic                     reset_this_cycle,
    input  line_table_pkg::bus_req_t bus,
    output logic [31:0]              read_data,
    output logic                     user_interrupt
);
    import line_table_pkg::*;

    logic       header_write;
    logic       status_write;
    logic       code_write;
    logic       write_active;
    logic       default_is_stmt;
    logic       consume;
    code_byte_t cur;
    exec_cmd_t  exec;
    flag_cmd_t  flags;
    am_state_t  am;

    code_buffer i_code_buffer (
        .clk              (clk),
        .reset_this_cycle (reset_this_cycle),
        .header_write     (header_write),
        .code_write       (code_write),
        .code_data        (bus.data),
        .code_size        (bus.write_size),
        .consume          (consume),
        .cur              (cur)
    );

    opcode_parser i_opcode_parser (
        .clk              (clk),
        .reset_this_cycle (reset_this_cycle),
        .header_write     (header_write),
        .status_write     (status_write),
        .write_active     (write_active),
        .cur              (cur),
        .consume          (consume),
        .exec             (exec),
        .flags            (flags)
    );

    line_machine i_line_machine (
        .clk              (clk),
        .reset_this_cycle (reset_this_cycle),
        .header_write     (header_write),
        .status_write     (status_write),
        .default_is_stmt  (default_is_stmt),
        .exec             (exec),
        .flags            (flags),
        .am               (am)
    );

    register_bank i_register_bank (
        .clk              (clk),
        .reset_this_cycle (reset_this_cycle),
        .bus              (bus),
        .copy             (flags.copy),
        .am               (am),
        .header_write     (header_write),
        .status_write     (status_write),
        .code_write       (code_write),
        .write_active     (write_active),
        .default_is_stmt  (default_is_stmt),
        .read_data        (read_data),
        .user_interrupt   (user_interrupt)
    );

endmodule

// File: source/register_bank.sv
// Register bank on the host bus
// Write decoding, header and STATUS registers, interrupt output
// Combinational read multiplexer with byte-lane masking

module register_bank (
    input  logic                      clk,
    input  logic                      reset_this_cycle,
    input  line_table_pkg::bus_req_t  bus,
    input  logic                      copy,
    input  line_table_pkg::am_state_t am,
    output logic                      header_write,
    output logic                      status_write,
    output logic                      code_write,
    output logic                      write_active,
    output logic                      default_is_stmt,
    output logic [31:0]               read_data,
    output logic                      user_interrupt
);
    import line_table_pkg::*;

    logic        header_is_stmt;
    logic        emit_row;
    logic [31:0] selected;

    assign write_active = bus.write_size != RW_NONE;
    assign header_write = write_active && bus.address == PROGRAM_HEADER;
    assign code_write   = write_active && bus.address == PROGRAM_CODE;
    assign status_write = write_active && bus.address == STATUS;

    always_ff @(posedge clk) begin
        if (reset_this_cycle) begin
            header_is_stmt <= 1'b0;
        end else if (header_write) begin
            header_is_stmt <= bus.data[0];
        end
    end

    // The machine loads is_stmt on the same edge as the header register
    assign default_is_stmt = header_write ? bus.data[0] : header_is_stmt;

    // STATUS reads 1 while a row waits for the host, and the interrupt follows it
    always_ff @(posedge clk) begin
        if (reset_this_cycle || header_write || status_write) begin
            emit_row <= 1'b0;
        end else if (copy) begin
            emit_row <= 1'b1;
        end
    end

    assign user_interrupt = emit_row;

    always_comb begin
        case (bus.address)
            PROGRAM_HEADER:    selected = {31'h0, header_is_stmt};
            AM_ADDRESS:        selected = {4'h0, am.address, 1'b0};
            AM_FILE:           selected = {16'h0, am.file};
            AM_LINE_COL_FLAGS: selected = {2'h0, am.epilogue_begin, am.prologue_end,
                                           am.basic_block, am.is_stmt, am.column, am.line};
            STATUS:            selected = {31'h0, emit_row};
            default:           selected = 32'h0;
        endcase
    end

    // Lanes outside the requested size read as zero
    assign read_data[7:0]   = bus.read_size != RW_NONE ? selected[7:0] : 8'h0;
    assign read_data[15:8]  = bus.read_size == RW_16 || bus.read_size == RW_32 ?
                              selected[15:8] : 8'h0;
    assign read_data[31:16] = bus.read_size == RW_32 ? selected[31:16] : 16'h0;

endmodule

// File: source/line_machine.sv
// Line-table abstract machine
// Address, file, line, column and the row flags
// One adder shared by advance_pc and advance_line

module line_machine (
    input  logic                      clk,
    input  logic                      reset_this_cycle,
    input  logic                      header_write,
    input  logic                      status_write,
    input  logic                      default_is_stmt,
    input  line_table_pkg::exec_cmd_t exec,
    input  line_table_pkg::flag_cmd_t flags,
    output line_table_pkg::am_state_t am
);
    import line_table_pkg::*;

    am_state_t            am_q;
    logic [OPERAND_W-1:0] adder_src;
    logic [OPERAND_W-1:0] adder_sum;
    logic                 add_line;

    assign add_line = exec.strobe && exec.instr == ADVANCE_LINE;

    // The two additions never happen in the same cycle
    assign adder_src = add_line ? OPERAND_W'(am_q.line) : {am_q.address, 1'b0};
    assign adder_sum = adder_src + exec.operand;

    always_ff @(posedge clk) begin
        if (reset_this_cycle || header_write) begin
            am_q.address <= '0;
            am_q.file    <= FILE_W'(1);
            am_q.line    <= LINE_W'(1);
            am_q.column  <= '0;
        end else if (exec.strobe) begin
            case (exec.instr)
                ADVANCE_PC:   am_q.address <= adder_sum[OPERAND_W-1:1];
                ADVANCE_LINE: am_q.line    <= adder_sum[LINE_W-1:0];
                SET_FILE:     am_q.file    <= exec.operand[FILE_W-1:0];
                SET_COLUMN:   am_q.column  <= exec.operand[COLUMN_W-1:0];
                default:      am_q.column  <= am_q.column;
            endcase
        end
    end

    // is_stmt survives a row emit and only returns to the header default
    always_ff @(posedge clk) begin
        if (reset_this_cycle) begin
            am_q.is_stmt <= 1'b0;
        end else if (header_write) begin
            am_q.is_stmt <= default_is_stmt;
        end else if (flags.negate_stmt) begin
            am_q.is_stmt <= !am_q.is_stmt;
        end
    end

    // Per-row flags are cleared once the host has taken the row
    always_ff @(posedge clk) begin
        if (reset_this_cycle || header_write || status_write) begin
            am_q.basic_block    <= 1'b0;
            am_q.prologue_end   <= 1'b0;
            am_q.epilogue_begin <= 1'b0;
        end else begin
            if (flags.set_basic_block) begin
                am_q.basic_block <= 1'b1;
            end
            if (flags.set_prologue_end) begin
                am_q.prologue_end <= 1'b1;
            end
            if (flags.set_epilogue_begin) begin
                am_q.epilogue_begin <= 1'b1;
            end
        end
    end

    assign am = am_q;

endmodule

// File: source/opcode_parser.sv
// Standard opcode parser
// Parse FSM, latched instruction and signedness, LEB128 and u16 operand assembly
// Drives the execute strobe and the single-byte flag opcode strobes

module opcode_parser (
    input  logic                       clk,
    input  logic                       reset_this_cycle,
    input  logic                       header_write,
    input  logic                       status_write,
    input  logic                       write_active,
    input  line_table_pkg::code_byte_t cur,
    output logic                       consume,
    output line_table_pkg::exec_cmd_t  exec,
    output line_table_pkg::flag_cmd_t  flags
);
    import line_table_pkg::*;

    parse_state_e         state;
    parse_state_e         next_state;
    instr_e               instr;
    instr_e               instr_dec;
    logic                 leb_signed;
    logic [OPERAND_W-1:0] operand;
    std_opcode_e          opcode;
    logic                 parse;
    logic                 exec_now;
    logic                 at_opcode;
    logic                 last_byte;
    logic                 sign_fill;

    assign opcode    = std_opcode_e'(cur.value);
    assign last_byte = !cur.value[7];

    // Bus writes take priority over both parsing and execution
    assign exec_now  = !write_active && state == EXEC;
    assign parse     = !write_active && state != EXEC && state != PAUSE_FOR_COPY && cur.valid;
    assign at_opcode = parse && state == READY;
    assign consume   = parse;

    // Every LEB byte fills the upper bits with its own sign, the last one wins
    assign sign_fill = leb_signed && cur.value[6];

    always_comb begin
        next_state = state;
        case (state)
            READY: begin
                case (opcode)
                    DW_LNS_COPY:             next_state = PAUSE_FOR_COPY;
                    DW_LNS_ADVANCE_PC,
                    DW_LNS_ADVANCE_LINE,
                    DW_LNS_SET_FILE,
                    DW_LNS_SET_COLUMN:       next_state = LEB_BYTE0;
                    DW_LNS_FIXED_ADVANCE_PC: next_state = U16_BYTE0;
                    default:                 next_state = READY;
                endcase
            end
            LEB_BYTE0:    next_state = last_byte ? EXEC : LEB_BYTE1;
            LEB_BYTE1:    next_state = last_byte ? EXEC : LEB_BYTE2;
            LEB_BYTE2:    next_state = last_byte ? EXEC : LEB_BYTE3;
            LEB_BYTE3:    next_state = last_byte ? EXEC : LEB_OVERFLOW;
            LEB_OVERFLOW: next_state = last_byte ? EXEC : LEB_OVERFLOW;
            U16_BYTE0:    next_state = U16_BYTE1;
            U16_BYTE1:    next_state = EXEC;
            default:      next_state = state;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset_this_cycle || header_write || status_write) begin
            state <= READY;
        end else if (exec_now) begin
            state <= READY;
        end else if (parse) begin
            state <= next_state;
        end
    end

    always_comb begin
        case (opcode)
            DW_LNS_ADVANCE_PC,
            DW_LNS_FIXED_ADVANCE_PC: instr_dec = ADVANCE_PC;
            DW_LNS_ADVANCE_LINE:     instr_dec = ADVANCE_LINE;
            DW_LNS_SET_FILE:         instr_dec = SET_FILE;
            DW_LNS_SET_COLUMN:       instr_dec = SET_COLUMN;
            default:                 instr_dec = NOP;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset_this_cycle || header_write || status_write) begin
            instr      <= NOP;
            leb_signed <= 1'b0;
        end else if (at_opcode) begin
            instr      <= instr_dec;
            leb_signed <= opcode == DW_LNS_ADVANCE_LINE;
        end
    end

    // Bytes after the fourth LEB byte are read but add nothing to the operand
    always_ff @(posedge clk) begin
        if (parse) begin
            case (state)
                LEB_BYTE0: operand <= {{(OPERAND_W - 7){sign_fill}}, cur.value[6:0]};
                LEB_BYTE1: operand <= {{(OPERAND_W - 14){sign_fill}}, cur.value[6:0],
                                       operand[6:0]};
                LEB_BYTE2: operand <= {{(OPERAND_W - 21){sign_fill}}, cur.value[6:0],
                                       operand[13:0]};
                LEB_BYTE3: operand <= {cur.value[6:0], operand[20:0]};
                U16_BYTE0: operand <= {{(OPERAND_W - 8){1'b0}}, cur.value};
                U16_BYTE1: operand <= {{(OPERAND_W - 16){1'b0}}, cur.value, operand[7:0]};
                default:   operand <= operand;
            endcase
        end
    end

    assign exec.strobe  = exec_now;
    assign exec.instr   = instr;
    assign exec.operand = operand;

    assign flags.negate_stmt        = at_opcode && opcode == DW_LNS_NEGATE_STMT;
    assign flags.set_basic_block    = at_opcode && opcode == DW_LNS_SET_BASIC_BLOCK;
    assign flags.set_prologue_end   = at_opcode && opcode == DW_LNS_SET_PROLOGUE_END;
    assign flags.set_epilogue_begin = at_opcode && opcode == DW_LNS_SET_EPILOGUE_BEGIN;
    assign flags.copy               = at_opcode && opcode == DW_LNS_COPY;

endmodule

// File: source/code_buffer.sv
// Program code buffer
// Holds the last chunk of 1, 2 or 4 code bytes and a byte pointer into it
// Presents the byte under the pointer together with its valid bit

module code_buffer (
    input  logic                    clk,
    input  logic                    reset_this_cycle,
    input  logic                    header_write,
    input  logic                    code_write,
    input  logic [31:0]             code_data,
    input  line_table_pkg::rw_size_e code_size,
    input  logic                    consume,
    output line_table_pkg::code_byte_t cur
);
    import line_table_pkg::*;

    logic [31:0] chunk;
    rw_size_e    chunk_size;
    // One bit wider than needed to index four bytes so it can point past the end
    logic [2:0]  ptr;

    always_ff @(posedge clk) begin
        if (code_write) begin
            case (code_size)
                RW_8:    chunk <= {24'h0, code_data[7:0]};
                RW_16:   chunk <= {16'h0, code_data[15:0]};
                default: chunk <= code_data;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (reset_this_cycle || header_write) begin
            chunk_size <= RW_NONE;
        end else if (code_write) begin
            chunk_size <= code_size;
        end
    end

    // A new chunk always starts parsing from its first byte
    always_ff @(posedge clk) begin
        if (reset_this_cycle || header_write || code_write) begin
            ptr <= 3'h0;
        end else if (consume) begin
            ptr <= ptr + 3'h1;
        end
    end

    always_comb begin
        case (ptr)
            3'h0:    cur.value = chunk[7:0];
            3'h1:    cur.value = chunk[15:8];
            3'h2:    cur.value = chunk[23:16];
            3'h3:    cur.value = chunk[31:24];
            default: cur.value = 8'h0;
        endcase
    end

    always_comb begin
        case (ptr)
            3'h0:    cur.valid = chunk_size != RW_NONE;
            3'h1:    cur.valid = chunk_size == RW_16 || chunk_size == RW_32;
            3'h2:    cur.valid = chunk_size == RW_32;
            3'h3:    cur.valid = chunk_size == RW_32;
            default: cur.valid = 1'b0;
        endcase
    end

endmodule

// File: source/line_table_pkg.sv
// Shared types for the DWARF line-table accelerator
// Register bus encodings, register map, standard opcodes, parser states and field widths
// Structs passed between the buffer, parser, abstract machine and register bank

package line_table_pkg;

    // Field widths of the abstract machine and the operand latch
    localparam int OPERAND_W = 28;
    localparam int LINE_W    = 16;
    localparam int FILE_W    = 16;
    localparam int COLUMN_W  = 10;

    // Byte-lane size code used by the register bus for both reads and writes
    typedef enum logic [1:0] {
        RW_8    = 2'h0,
        RW_16   = 2'h1,
        RW_32   = 2'h2,
        RW_NONE = 2'h3
    } rw_size_e;

    typedef enum logic [5:0] {
        PROGRAM_HEADER    = 6'h0,
        PROGRAM_CODE      = 6'h1,
        AM_ADDRESS        = 6'h2,
        AM_FILE           = 6'h3,
        AM_LINE_COL_FLAGS = 6'h4,
        STATUS            = 6'h5
    } reg_addr_e;

    // Standard opcodes handled here, all other bytes are skipped
    typedef enum logic [7:0] {
        DW_LNS_COPY               = 8'h01,
        DW_LNS_ADVANCE_PC         = 8'h02,
        DW_LNS_ADVANCE_LINE       = 8'h03,
        DW_LNS_SET_FILE           = 8'h04,
        DW_LNS_SET_COLUMN         = 8'h05,
        DW_LNS_NEGATE_STMT        = 8'h06,
        DW_LNS_SET_BASIC_BLOCK    = 8'h07,
        DW_LNS_FIXED_ADVANCE_PC   = 8'h09,
        DW_LNS_SET_PROLOGUE_END   = 8'h0A,
        DW_LNS_SET_EPILOGUE_BEGIN = 8'h0B
    } std_opcode_e;

    typedef enum logic [3:0] {
        READY,
        PAUSE_FOR_COPY,
        LEB_BYTE0,
        LEB_BYTE1,
        LEB_BYTE2,
        LEB_BYTE3,
        LEB_OVERFLOW,
        U16_BYTE0,
        U16_BYTE1,
        EXEC
    } parse_state_e;

    typedef enum logic [2:0] {
        NOP,
        ADVANCE_PC,
        ADVANCE_LINE,
        SET_FILE,
        SET_COLUMN
    } instr_e;

    typedef struct packed {
        reg_addr_e   address;
        logic [31:0] data;
        rw_size_e    write_size;
        rw_size_e    read_size;
    } bus_req_t;

    typedef struct packed {
        logic [7:0] value;
        logic       valid;
    } code_byte_t;

    typedef struct packed {
        logic                 strobe;
        instr_e               instr;
        logic [OPERAND_W-1:0] operand;
    } exec_cmd_t;

    typedef struct packed {
        logic negate_stmt;
        logic set_basic_block;
        logic set_prologue_end;
        logic set_epilogue_begin;
        logic copy;
    } flag_cmd_t;

    // The address is held without bit 0 since instructions are 2-byte aligned
    typedef struct packed {
        logic [OPERAND_W-1:1] address;
        logic [FILE_W-1:0]    file;
        logic [LINE_W-1:0]    line;
        logic [COLUMN_W-1:0]  column;
        logic                 is_stmt;
        logic                 basic_block;
        logic                 prologue_end;
        logic                 epilogue_begin;
    } am_state_t;

endpackage
